//--- Bender.yml
package:
  name: cpu8_core

sources:
  - hdl/cpu_pkg.sv
  - hdl/control_unit.sv
  - hdl/alu.sv
  - hdl/reg_file.sv
  - hdl/pc_unit.sv
  - hdl/data_mem.sv
  - hdl/cpu_top.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_cpu.sv

//--- filelist.f
hdl/cpu_pkg.sv
hdl/control_unit.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/pc_unit.sv
hdl/data_mem.sv
hdl/cpu_top.sv
tb/tb_clk_gen.sv
tb/tb_cpu.sv

//--- hdl/alu.sv
// 8-bit ALU for the core
// Forward, add, logic, multiply, shift and rotate, selected by alu_op_e
// Zero flag feeds the BEQ and BNE decision in pc_unit

module alu (
    input  cpu_pkg::alu_op_e          op,
    input  logic [cpu_pkg::DATA_W-1:0] a,
    input  logic [cpu_pkg::DATA_W-1:0] b,
    output logic [cpu_pkg::DATA_W-1:0] result,
    output logic                       zero
);
    import cpu_pkg::*;

    logic [2:0]          shamt;                 // Shift and rotate distance
    logic [2*DATA_W-1:0] rot;                   // Doubled operand for rotate

    assign shamt = b[2:0];
    assign rot   = {a, a} >> shamt;

    // ==================================================
    // Operation select
    // ==================================================
    always_comb begin
        unique case (op)
            ALU_FWD: result = b;                // MOV, LOADI, load/store address
            ALU_ADD: result = a + b;            // Carry dropped
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_MUL: result = a * b;            // Low byte only
            ALU_SLL: result = a << shamt;
            ALU_SRA: result = $signed(a) >>> shamt;   // Sign fill
            ALU_ROR: result = rot[DATA_W-1:0];
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);               // Set on equal compare

endmodule

//--- hdl/control_unit.sv
// Opcode decoder for the core
// Maps each opcode onto a ctrl_t bundle and turns memory busywait into the core stall
// Purely combinational, one instance in cpu_top

module control_unit (
    input  cpu_pkg::opcode_e opcode,
    input  logic             busywait,
    output cpu_pkg::ctrl_t   ctrl,
    output logic             hold
);
    import cpu_pkg::*;

    assign hold = busywait;                     // Freeze pc and regs during access

    // ==================================================
    // Opcode decode
    // ==================================================
    always_comb begin
        ctrl = '0;                              // No-op for undefined opcodes
        unique case (opcode)
            OP_ADD: begin
                ctrl.wr_en   = 1'b1;
                ctrl.alu_src = 1'b1;            // rs2
                ctrl.alu_op  = ALU_ADD;
            end
            OP_SUB: begin
                ctrl.wr_en   = 1'b1;
                ctrl.alu_src = 1'b1;
                ctrl.negate  = 1'b1;            // a + (-b)
                ctrl.alu_op  = ALU_ADD;
            end
            OP_AND: begin
                ctrl.wr_en   = 1'b1;
                ctrl.alu_src = 1'b1;
                ctrl.alu_op  = ALU_AND;
            end
            OP_OR: begin
                ctrl.wr_en   = 1'b1;
                ctrl.alu_src = 1'b1;
                ctrl.alu_op  = ALU_OR;
            end
            OP_MOV: begin
                ctrl.wr_en   = 1'b1;
                ctrl.alu_src = 1'b1;            // Forward rs2
            end
            OP_LOADI: begin
                ctrl.wr_en   = 1'b1;            // Forward imm
            end
            OP_J: begin
                ctrl.branch  = BR_JUMP;
            end
            OP_BEQ, OP_BNE: begin
                ctrl.alu_src = 1'b1;            // Compare by subtract
                ctrl.negate  = 1'b1;
                ctrl.alu_op  = ALU_ADD;
                ctrl.branch  = (opcode == OP_BEQ) ? BR_BEQ : BR_BNE;
            end
            OP_MULT: begin
                ctrl.wr_en   = 1'b1;
                ctrl.alu_src = 1'b1;
                ctrl.alu_op  = ALU_MUL;
            end
            OP_SL: begin
                ctrl.wr_en   = 1'b1;            // Shift amount from imm
                ctrl.alu_op  = ALU_SLL;
            end
            OP_SRA: begin
                ctrl.wr_en   = 1'b1;
                ctrl.alu_op  = ALU_SRA;
            end
            OP_ROR: begin
                ctrl.wr_en   = 1'b1;
                ctrl.alu_op  = ALU_ROR;
            end
            OP_LWD, OP_LWI: begin
                ctrl.wr_en    = 1'b1;
                ctrl.alu_src  = (opcode == OP_LWD);   // Address from rs2 or imm
                ctrl.mem_read = 1'b1;
                ctrl.wb_src   = 1'b1;           // Load data to rd
            end
            OP_SWD, OP_SWI: begin
                ctrl.alu_src   = (opcode == OP_SWD);
                ctrl.mem_write = 1'b1;          // Store rs1
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    // One request kind per access, the sequencer has a single port
    a_rw_excl: assert final (!(ctrl.mem_read && ctrl.mem_write));

endmodule

//--- hdl/cpu_pkg.sv
// Shared ISA definitions for the 8-bit single-cycle core
// Holds opcode, ALU, branch and memory-state enums plus the control and retire structs
// Imported by every RTL block and by the testbench

package cpu_pkg;

    // ==================================================
    // Widths and timing constants
    // ==================================================
    localparam int DATA_W     = 8;                    // Datapath width
    localparam int REG_ADDR_W = 3;                    // Eight registers
    localparam int PC_W       = 32;                   // Byte address of instruction
    localparam int MEM_WAIT   = 2;                    // Busy cycles per data access
    localparam int MEM_DEPTH  = 1 << DATA_W;          // Byte-addressed, full 8-bit range
    localparam int WAIT_CNT_W = $clog2(MEM_WAIT + 1); // Sequencer counter width

    // ==================================================
    // Instruction set
    // ==================================================
    typedef enum logic [7:0] {
        OP_ADD   = 8'h00,   // rd = rs1 + rs2
        OP_SUB   = 8'h01,   // rd = rs1 - rs2
        OP_AND   = 8'h02,
        OP_OR    = 8'h03,
        OP_MOV   = 8'h04,   // rd = rs2
        OP_LOADI = 8'h05,   // rd = imm
        OP_J     = 8'h06,   // Unconditional, offset in dest field
        OP_BEQ   = 8'h07,
        OP_BNE   = 8'h08,
        OP_MULT  = 8'h09,   // Low byte of product
        OP_SL    = 8'h0A,
        OP_SRA   = 8'h0C,   // 0x0B left undefined
        OP_ROR   = 8'h0D,
        OP_LWD   = 8'h0E,   // rd = mem[rs2]
        OP_LWI   = 8'h0F,   // rd = mem[imm]
        OP_SWD   = 8'h10,   // mem[rs2] = rs1
        OP_SWI   = 8'h11    // mem[imm] = rs1
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_FWD = 3'b000,   // Pass operand b
        ALU_ADD = 3'b001,   // Also used for SUB and compare
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_MUL = 3'b100,
        ALU_SLL = 3'b101,
        ALU_SRA = 3'b110,
        ALU_ROR = 3'b111
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE = 2'b00,    // Sequential pc+4
        BR_JUMP = 2'b01,
        BR_BEQ  = 2'b10,    // Taken on zero
        BR_BNE  = 2'b11     // Taken on non-zero
    } branch_e;

    typedef enum logic [1:0] {
        MEM_IDLE = 2'b00,
        MEM_BUSY = 2'b01,
        MEM_DONE = 2'b10
    } mem_state_e;

    // ==================================================
    // Datapath bundles
    // ==================================================
    typedef struct packed {
        logic    wr_en;     // Register write-back
        logic    alu_src;   // 1 register, 0 immediate
        logic    negate;    // Two's complement operand b
        alu_op_e alu_op;
        branch_e branch;
        logic    mem_read;
        logic    mem_write;
        logic    wb_src;    // 1 memory data, 0 ALU result
    } ctrl_t;

    typedef struct packed {
        logic                  valid;   // One-cycle strobe per write-back
        logic [REG_ADDR_W-1:0] rd;
        logic [DATA_W-1:0]     data;
    } retire_t;

endpackage

//--- hdl/cpu_top.sv
// Top level of the 8-bit single-cycle core
// Splits the fetched instruction word, builds operand and write-back muxes, wires the blocks
// Instruction memory lives outside, driven from pc

module cpu_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [31:0]              instr,
    output logic [cpu_pkg::PC_W-1:0] pc,
    output cpu_pkg::retire_t         retire
);
    import cpu_pkg::*;

    // ==================================================
    // Instruction fields
    // ==================================================
    opcode_e               opcode;
    logic [7:0]            dest_field;          // rd or branch offset
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [DATA_W-1:0]     imm;

    assign opcode     = opcode_e'(instr[31:24]);  // Unlisted codes decode as no-op
    assign dest_field = instr[23:16];
    assign rs1        = instr[8 +: REG_ADDR_W];
    assign rs2        = instr[0 +: REG_ADDR_W];
    assign imm        = instr[7:0];

    ctrl_t             ctrl;
    logic              hold;
    logic              busywait;
    logic              reg_we;                  // Write enable after stall gating
    logic [DATA_W-1:0] rd_data1;
    logic [DATA_W-1:0] rd_data2;
    logic [DATA_W-1:0] src_b;                   // Register or immediate
    logic [DATA_W-1:0] alu_b;                   // After optional negation
    logic [DATA_W-1:0] alu_result;
    logic              zero;
    logic [DATA_W-1:0] mem_rdata;
    logic [DATA_W-1:0] wb_data;

    control_unit u_ctrl (
        .opcode   (opcode),
        .busywait (busywait),
        .ctrl     (ctrl),
        .hold     (hold)
    );

    // ==================================================
    // Operand path
    // ==================================================
    assign src_b = ctrl.alu_src ? rd_data2 : imm;
    assign alu_b = ctrl.negate ? (~src_b + 1'b1) : src_b;   // SUB and compare
    assign reg_we  = ctrl.wr_en && !hold;
    assign wb_data = ctrl.wb_src ? mem_rdata : alu_result;

    reg_file u_rf (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (reg_we),
        .wr_addr  (dest_field[REG_ADDR_W-1:0]),
        .wr_data  (wb_data),
        .rd_addr1 (rs1),
        .rd_addr2 (rs2),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2)
    );

    alu u_alu (
        .op     (ctrl.alu_op),
        .a      (rd_data1),
        .b      (alu_b),
        .result (alu_result),
        .zero   (zero)
    );

    pc_unit u_pc (
        .clk    (clk),
        .rst_n  (rst_n),
        .branch (ctrl.branch),
        .zero   (zero),
        .offset (dest_field),
        .hold   (hold),
        .pc     (pc)
    );

    data_mem u_dmem (
        .clk        (clk),
        .rst_n      (rst_n),
        .read       (ctrl.mem_read),
        .write      (ctrl.mem_write),
        .address    (alu_result),               // Forwarded rs2 or imm
        .write_data (rd_data1),                 // Store source is rs1
        .read_data  (mem_rdata),
        .busywait   (busywait)
    );

    // Retirement strobe matches the register write edge
    assign retire.valid = reg_we;
    assign retire.rd    = dest_field[REG_ADDR_W-1:0];
    assign retire.data  = wb_data;

endmodule

//--- hdl/data_mem.sv
// Data memory, 256 bytes with a fixed-latency access sequencer
// A held read or write request raises busywait until the DONE cycle
// Read data is valid and a write commits in DONE

module data_mem (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       read,
    input  logic                       write,
    input  logic [cpu_pkg::DATA_W-1:0] address,
    input  logic [cpu_pkg::DATA_W-1:0] write_data,
    output logic [cpu_pkg::DATA_W-1:0] read_data,
    output logic                       busywait
);
    import cpu_pkg::*;

    mem_state_e            state;
    logic [WAIT_CNT_W-1:0] wait_cnt;            // Cycles spent in BUSY
    logic [DATA_W-1:0]     mem [MEM_DEPTH];
    logic [DATA_W-1:0]     rd_q;                // Captured on entry to DONE
    logic                  req;

    assign req = read || write;

    // Raised in the request cycle already, so the core never advances early
    assign busywait  = (state == MEM_BUSY) || (state == MEM_IDLE && req);
    assign read_data = rd_q;

    // ==================================================
    // Access sequencer
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= MEM_IDLE;
            wait_cnt <= '0;
        end else begin
            unique case (state)
                MEM_IDLE: if (req) begin
                    state    <= MEM_BUSY;
                    wait_cnt <= '0;
                end
                MEM_BUSY: if (wait_cnt == WAIT_CNT_W'(MEM_WAIT - 1)) begin
                    state <= MEM_DONE;          // busywait drops here
                end else begin
                    wait_cnt <= wait_cnt + 1'b1;
                end
                default: state <= MEM_IDLE;     // DONE lasts one cycle
            endcase
        end
    end

    // Storage and read capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (state == MEM_DONE && write) begin
            mem[address] <= write_data;         // Commit at end of DONE
        end
    end

    always_ff @(posedge clk) begin
        if (state == MEM_BUSY && wait_cnt == WAIT_CNT_W'(MEM_WAIT - 1)) begin
            rd_q <= mem[address];
        end
    end

    a_addr_stable: assert property (
        @(posedge clk) disable iff (!rst_n) (state == MEM_BUSY) |-> $stable(address)
    );

endmodule

//--- hdl/pc_unit.sv
// Program counter for the core
// Sequential, jump and conditional branch update, frozen while the core stalls
// Branch offset counts words relative to pc+4

module pc_unit (
    input  logic                       clk,
    input  logic                       rst_n,
    input  cpu_pkg::branch_e           branch,
    input  logic                       zero,
    input  logic [7:0]                 offset,
    input  logic                       hold,
    output logic [cpu_pkg::PC_W-1:0]   pc
);
    import cpu_pkg::*;

    logic [PC_W-1:0] pc_plus4;
    logic [PC_W-1:0] target;                    // Branch destination
    logic            taken;

    assign pc_plus4 = pc + PC_W'(4);
    assign target   = pc_plus4 + {{(PC_W-10){offset[7]}}, offset, 2'b00};

    always_comb begin
        unique case (branch)
            BR_JUMP: taken = 1'b1;
            BR_BEQ:  taken = zero;              // rs1 == rs2
            BR_BNE:  taken = !zero;
            default: taken = 1'b0;
        endcase
    end

    // ==================================================
    // PC register
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (!hold) begin               // Stall keeps current instruction
            pc <= taken ? target : pc_plus4;
        end
    end

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00
    );

endmodule

//--- hdl/reg_file.sv
// Register file, eight 8-bit registers
// Two combinational read ports, one write port on the rising clock edge
// All registers clear on reset

module reg_file (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           wr_en,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] wr_addr,
    input  logic [cpu_pkg::DATA_W-1:0]     wr_data,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] rd_addr1,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] rd_addr2,
    output logic [cpu_pkg::DATA_W-1:0]     rd_data1,
    output logic [cpu_pkg::DATA_W-1:0]     rd_data2
);
    import cpu_pkg::*;

    logic [DATA_W-1:0] regs [1 << REG_ADDR_W];  // r0 is an ordinary register

    // Write port
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < (1 << REG_ADDR_W); i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;           // Gated by hold in top
        end
    end

    // Read ports, no bypass
    assign rd_data1 = regs[rd_addr1];
    assign rd_data2 = regs[rd_addr2];

endmodule

//--- tb/tb_clk_gen.sv
// Clock and reset source for the core testbench
// Free-running clock, rst_n released on the last reset edge

module tb_clk_gen #(
    parameter int PERIOD_T   = 100,
    parameter int RST_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_T / 2) clk = ~clk;     // 50/50 duty
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;                          // DUT still sees reset on this edge
    end

endmodule

//--- tb/tb_cpu.sv
// Testbench for the 8-bit single-cycle core
// Feeds a program table by pc and checks pc and the retire port every cycle
// Expected values come from a cycle-level shadow model of the ISA

module tb_cpu;
    import cpu_pkg::*;

    // ==================================================
    // Run constants and signals
    // ==================================================
    localparam int          PERIOD_T   = 100;
    localparam int          RST_CYCLES = 8;
    localparam int          PROG_LEN   = 34;
    localparam logic [31:0] NOP_WORD   = 32'hFF00_0000;   // Unlisted opcode
    localparam logic [7:0]  SKIP_VAL   = 8'hEE;           // Rows that must be jumped over

    logic            clk;
    logic            rst_n;
    logic [31:0]     instr;
    logic [PC_W-1:0] pc;
    retire_t         retire;

    logic [31:0]     prog [PROG_LEN];           // Instruction words by pc/4
    logic [PC_W-1:0] m_pc;                      // Shadow model state
    logic [7:0]      m_regs [8];
    logic [7:0]      m_mem [256];
    int              stall_left;                // Hold cycles left for current instr
    int              errors;
    int              checks;
    int              retired;
    int              loads_retired;
    int              loads_expected;

    tb_clk_gen #(.PERIOD_T(PERIOD_T), .RST_CYCLES(RST_CYCLES)) u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    cpu_top dut0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .instr  (instr),
        .pc     (pc),
        .retire (retire)
    );

    // ==================================================
    // ISA helpers
    // ==================================================
    function automatic logic [31:0] encode(opcode_e op, logic [7:0] f2, logic [7:0] f1,
                                           logic [7:0] f0);
        return {op, f2, f1, f0};
    endfunction

    function automatic logic is_mem(logic [31:0] w);
        return w[31:24] inside {OP_LWD, OP_LWI, OP_SWD, OP_SWI};
    endfunction

    function automatic logic writes_reg(logic [31:0] w);
        return w[31:24] inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_MOV, OP_LOADI,
                                OP_MULT, OP_SL, OP_SRA, OP_ROR, OP_LWD, OP_LWI};
    endfunction

    function automatic logic [7:0] shift_right_signed(logic [7:0] a, logic [2:0] n);
        logic [7:0] v;
        v = a;
        for (int i = 0; i < n; i++) begin
            v = {v[7], v[7:1]};                 // Copy sign bit in
        end
        return v;
    endfunction

    function automatic logic [7:0] rotate_right(logic [7:0] a, logic [2:0] n);
        logic [7:0] v;
        v = a;
        for (int i = 0; i < n; i++) begin
            v = {v[0], v[7:1]};                 // Bit 0 wraps to bit 7
        end
        return v;
    endfunction

    function automatic logic [PC_W-1:0] branch_target(logic [PC_W-1:0] cur, logic [7:0] off);
        int signed words;
        words = $signed(off);
        return cur + 4 + words * 4;             // Word offset from pc+4
    endfunction

    function automatic logic [31:0] fetch_word(logic [PC_W-1:0] addr);
        logic [PC_W-1:0] idx;
        idx = addr >> 2;
        if (idx < PROG_LEN) begin
            return prog[idx];
        end else begin
            return NOP_WORD;                    // Past the end of the table
        end
    endfunction

    function automatic logic [7:0] predict_data(logic [31:0] w);
        logic [7:0]  a;
        logic [7:0]  b;
        logic [7:0]  imm;
        logic [15:0] prod;
        a    = m_regs[w[10:8]];
        b    = m_regs[w[2:0]];
        imm  = w[7:0];
        prod = a * b;
        case (w[31:24])
            OP_ADD:   return a + b;
            OP_SUB:   return a - b;
            OP_AND:   return a & b;
            OP_OR:    return a | b;
            OP_MOV:   return b;
            OP_LOADI: return imm;
            OP_MULT:  return prod[7:0];
            OP_SL:    return a << imm[2:0];
            OP_SRA:   return shift_right_signed(a, imm[2:0]);
            OP_ROR:   return rotate_right(a, imm[2:0]);
            OP_LWD:   return m_mem[b];
            OP_LWI:   return m_mem[imm];
            default:  return 8'h00;
        endcase
    endfunction

    // ==================================================
    // Model update and checks
    // ==================================================
    task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] got);
        errors++;
        $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, got);
    endtask

    task automatic advance_model(logic [31:0] w);
        logic [7:0] a;
        logic [7:0] b;
        logic       taken;
        a = m_regs[w[10:8]];
        b = m_regs[w[2:0]];
        if (stall_left > 0) begin
            stall_left--;                       // pc frozen while busy
        end else begin
            if (writes_reg(w)) begin
                m_regs[w[18:16]] = predict_data(w);
            end
            if (w[31:24] inside {OP_LWD, OP_LWI}) begin
                loads_expected++;
            end
            if (w[31:24] == OP_SWD) begin
                m_mem[b] = a;
            end
            if (w[31:24] == OP_SWI) begin
                m_mem[w[7:0]] = a;
            end
            taken = (w[31:24] == OP_J) || (w[31:24] == OP_BEQ && a == b)
                    || (w[31:24] == OP_BNE && a != b);
            m_pc = taken ? branch_target(m_pc, w[23:16]) : m_pc + 4;
            stall_left = is_mem(fetch_word(m_pc)) ? MEM_WAIT + 1 : 0;
        end
    endtask

    task automatic check_cycle(logic [31:0] w);
        retire_t exp;
        exp.valid = (stall_left == 0) && writes_reg(w);
        exp.rd    = w[18:16];
        exp.data  = predict_data(w);
        checks += 2;
        if (pc !== m_pc) begin
            report_mismatch("pc", m_pc, pc);
        end
        if (retire.valid !== exp.valid) begin
            report_mismatch("retire.valid", exp.valid, retire.valid);
        end
        if (retire.valid === 1'b1) begin
            retired++;
            if (is_mem(w)) begin
                loads_retired++;
            end
        end
        if (exp.valid) begin
            checks += 2;
            if (retire.rd !== exp.rd) begin
                report_mismatch("retire.rd", exp.rd, retire.rd);
            end
            if (retire.data !== exp.data) begin
                report_mismatch("retire.data", exp.data, retire.data);
            end
        end
    endtask

    task automatic build_program();
        prog[0]  = encode(OP_LOADI, 8'd1, 8'd0, 8'($urandom));
        prog[1]  = encode(OP_LOADI, 8'd2, 8'd0, 8'($urandom));
        prog[2]  = encode(OP_LOADI, 8'd3, 8'd0, 8'($urandom) | 8'h80);   // Negative for SRA
        prog[3]  = encode(OP_LOADI, 8'd4, 8'd0, 8'($urandom));
        prog[4]  = encode(OP_MOV,   8'd5, 8'd0, 8'd1);
        prog[5]  = encode(OP_ADD,   8'd6, 8'd1, 8'd2);
        prog[6]  = encode(OP_SUB,   8'd7, 8'd1, 8'd2);
        prog[7]  = encode(OP_AND,   8'd0, 8'd1, 8'd2);
        prog[8]  = encode(OP_OR,    8'd5, 8'd2, 8'd4);
        prog[9]  = encode(OP_MULT,  8'd6, 8'd1, 8'd2);
        prog[10] = encode(OP_SL,    8'd7, 8'd1, 8'd3);
        prog[11] = encode(OP_SRA,   8'd0, 8'd3, 8'd5);
        prog[12] = encode(OP_ROR,   8'd5, 8'd4, 8'd3);
        prog[13] = encode(OP_ROR,   8'd6, 8'd3, 8'd7);
        prog[14] = encode(OP_SWI,   8'd0, 8'd1, 8'h40);  // mem[0x40] = r1
        prog[15] = encode(OP_LOADI, 8'd2, 8'd0, 8'h41);
        prog[16] = encode(OP_SWD,   8'd0, 8'd4, 8'd2);   // mem[r2] = r4
        prog[17] = encode(OP_LWI,   8'd7, 8'd0, 8'h40);
        prog[18] = encode(OP_LWD,   8'd0, 8'd0, 8'd2);
        prog[19] = {8'h0B, 24'h01_0203};                  // Undefined opcode
        prog[20] = encode(OP_J,     8'd1, 8'd0, 8'd0);   // To 22
        prog[21] = encode(OP_LOADI, 8'd1, 8'd0, SKIP_VAL);
        prog[22] = encode(OP_BEQ,   8'd1, 8'd5, 8'd5);   // Taken, to 24
        prog[23] = encode(OP_LOADI, 8'd1, 8'd0, SKIP_VAL);
        prog[24] = encode(OP_BNE,   8'd3, 8'd5, 8'd5);   // Falls through
        prog[25] = encode(OP_BNE,   8'd1, 8'd3, 8'd2);   // Taken, to 27
        prog[26] = encode(OP_LOADI, 8'd1, 8'd0, SKIP_VAL);
        prog[27] = encode(OP_BEQ,   8'd2, 8'd3, 8'd2);   // Falls through
        prog[28] = encode(OP_J,     8'd2, 8'd0, 8'd0);   // To 31
        prog[29] = encode(OP_LOADI, 8'd4, 8'd0, 8'($urandom));
        prog[30] = encode(OP_J,     8'd2, 8'd0, 8'd0);   // To 33
        prog[31] = encode(OP_J,     8'hFD, 8'd0, 8'd0);  // Backward, to 29
        prog[32] = encode(OP_LOADI, 8'd1, 8'd0, SKIP_VAL);
        prog[33] = encode(OP_ADD,   8'd1, 8'd4, 8'd7);
    endtask

    // ==================================================
    // Stimulus
    // ==================================================
    initial begin
        void'($urandom(32'he73e_d4bc));
        errors         = 0;
        checks         = 0;
        retired        = 0;
        loads_retired  = 0;
        loads_expected = 0;
        build_program();
        for (int i = 0; i < 8; i++) begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            m_mem[i] = '0;
        end
        m_pc       = '0;
        instr      = NOP_WORD;                  // Harmless word during reset
        stall_left = is_mem(prog[0]) ? MEM_WAIT + 1 : 0;

        // Reset phase, pc at 0 and no strobe
        for (int k = 1; k <= RST_CYCLES; k++) begin
            @(posedge clk);
            if (k < RST_CYCLES) begin
                @(negedge clk);
                checks += 2;
                if (pc !== '0) begin
                    report_mismatch("pc", '0, pc);
                end
                if (retire.valid !== 1'b0) begin
                    report_mismatch("retire.valid", 1'b0, retire.valid);
                end
            end
        end
        instr <= prog[0];                       // Same edge that releases reset

        while (m_pc < PC_W'(PROG_LEN * 4)) begin
            @(negedge clk);
            check_cycle(fetch_word(m_pc));
            @(posedge clk);
            advance_model(fetch_word(m_pc));
            instr <= fetch_word(m_pc);
        end

        checks++;
        if (loads_retired != loads_expected) begin
            report_mismatch("load retirements", loads_expected, loads_retired);
        end
        $display("checks %0d, errors %0d, retirements %0d", checks, errors, retired);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Watchdog scaled by program length
    initial begin
        #((RST_CYCLES + 40 * PROG_LEN) * PERIOD_T);
        $display("Watchdog expired before the program reached its end, %0d errors", errors);
        $display("sim failed");
        $finish;
    end

endmodule
